// ==== tests/core_tests.txt ====
# I <byte address> <instruction word>   program image
# S <byte address> <store data>         expected stores, in order
I 00000000 00001fb7
I 00000004 00500093
I 00000008 ffd08113
I 0000000c 002081b3
I 00000010 003fa023
I 00000014 40110233
I 00000018 004fa223
I 0000001c 001242b3
I 00000020 4012d333
I 00000024 0042d393
I 00000028 0043f433
I 0000002c 006fa423
I 00000030 008fa623
I 00000034 001224b3
I 00000038 00123533
I 0000003c 01f49593
I 00000040 00a58633
I 00000044 00cfa823
I 00000048 12345697
I 0000004c 00dfaa23
I 00000050 00108033
I 00000054 000fac23
I 00000058 7f006713
I 0000005c 00efae23
I 00000060 000fa783
I 00000064 00178813
I 00000068 030fa023
I 0000006c 004fa883
I 00000070 031fa223
I 00000074 00108463
I 00000078 021fae23
I 0000007c 00209463
I 00000080 021fae23
I 00000084 00124463
I 00000088 021fae23
I 0000008c 0040d463
I 00000090 021fae23
I 00000094 0040e463
I 00000098 021fae23
I 0000009c 00127463
I 000000a0 021fae23
I 000000a4 00208463
I 000000a8 00100a13
I 000000ac 00109463
I 000000b0 001a0a13
I 000000b4 0040c463
I 000000b8 001a0a13
I 000000bc 00125463
I 000000c0 001a0a13
I 000000c4 00126463
I 000000c8 001a0a13
I 000000cc 0040f463
I 000000d0 001a0a13
I 000000d4 034fa423
I 000000d8 00800aef
I 000000dc 021fae23
I 000000e0 035fa623
I 000000e4 0f500b13
I 000000e8 000b0be7
I 000000ec 021fae23
I 000000f0 021fae23
I 000000f4 037fa823
I 000000f8 00010c37
I 000000fc fe1c2e23
I 00000100 0000006f
S 00001000 00000007
S 00001004 fffffffd
S 00001008 ffffffff
S 0000100c 0ffffffd
S 00001010 80000000
S 00001014 12345048
S 00001018 00000000
S 0000101c 000007f0
S 00001020 00000008
S 00001024 fffffffd
S 00001028 00000006
S 0000102c 000000dc
S 00001030 000000ec
S 0000fffc 00000005

// ==== sim.f ====
hdl/rv32i_pkg.sv
hdl/pipe_reg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/hazard_ctrl.sv
hdl/rv32i_core.sv
tests/clk_gen.sv
tests/mem_model.sv
tests/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - files:
      - hdl/rv32i_pkg.sv
      - hdl/pipe_reg.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/mem_stage.sv
      - hdl/hazard_ctrl.sv
      - hdl/rv32i_core.sv
  - target: test
    files:
      - tests/clk_gen.sv
      - tests/mem_model.sv
      - tests/core_tb.sv

// ==== tests/core_tb.sv ====
module core_tb;
    import rv32i_pkg::*;

    logic      clk, rst;
    rv32i_word imem_address, imem_rdata;
    logic      imem_read, imem_resp;
    rv32i_word dmem_address, dmem_rdata, dmem_wdata;
    logic      dmem_read, dmem_write, dmem_resp;
    logic [3:0] dmem_wmask;

    rv32i_word exp_addr_q [$]; // expected stores, in order
    rv32i_word exp_data_q [$];
    int        mismatches;
    int        other_errors;
    int        n_words;
    logic      loaded;
    logic      finished;
    logic      first_fetch_seen;

    clk_gen u_clk_gen (.clk(clk), .rst(rst));

    mem_model u_mem (
        .clk(clk), .rst(rst),
        .imem_address(imem_address), .imem_read(imem_read),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .dmem_address(dmem_address), .dmem_read(dmem_read), .dmem_write(dmem_write),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp)
    );

    rv32i_core u_rv32i_core (
        .clk(clk), .rst(rst),
        .imem_address(imem_address), .imem_read(imem_read),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .dmem_address(dmem_address), .dmem_read(dmem_read), .dmem_write(dmem_write),
        .dmem_wmask(dmem_wmask), .dmem_rdata(dmem_rdata), .dmem_wdata(dmem_wdata),
        .dmem_resp(dmem_resp)
    );

    task automatic check_store(input rv32i_word addr, input rv32i_word data,
                               input rv32i_word exp_addr, input rv32i_word exp_data);
        if (addr !== exp_addr || data !== exp_data) begin
            mismatches++;
            $display("mismatch at %0t: store %h <= %h, expected %h <= %h",
                     $time, addr, data, exp_addr, exp_data);
        end
    endtask

    task automatic check_mask(input logic [3:0] mask);
        if (mask !== 4'b1111) begin
            mismatches++;
            $display("mismatch at %0t: write mask %b, expected 1111", $time, mask);
        end
    endtask

    task automatic check_pc(input rv32i_word got, input rv32i_word exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: first fetch address %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic load_tests();
        int        fd;
        int        n;
        string     line;
        byte       kind;
        rv32i_word a, b;
        fd = $fopen("tests/core_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open tests/core_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h", kind, a, b);
                if (n == 3 && kind == "I") begin
                    u_mem.mem[a[15:2]] = b;
                    n_words++;
                end else if (n == 3 && kind == "S") begin
                    exp_addr_q.push_back(a);
                    exp_data_q.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    // runs on the rising edge, all DUT outputs settled since the falling edge
    always @(posedge clk) begin
        if (rst) begin
            if (dmem_read || dmem_write || imem_read) begin
                other_errors++;
                $display("memory request seen during reset at %0t", $time);
            end
        end else if (!finished) begin
            if (!first_fetch_seen && imem_read) begin
                check_pc(imem_address, reset_pc);
                first_fetch_seen = 1'b1;
            end
            if (dmem_write && dmem_resp) begin
                check_mask(dmem_wmask);
                if (exp_addr_q.size() == 0) begin
                    other_errors++;
                    $display("store to %h with data %h was not expected", dmem_address,
                             dmem_wdata);
                end else begin
                    check_store(dmem_address, dmem_wdata, exp_addr_q.pop_front(),
                                exp_data_q.pop_front());
                end
                if (dmem_address == 32'h0000_fffc) begin
                    finished = 1'b1; // end marker store
                end
            end
        end
    end

    initial begin
        mismatches       = 0;
        other_errors     = 0;
        n_words          = 0;
        loaded           = 1'b0;
        finished         = 1'b0;
        first_fetch_seen = 1'b0;
        #1;
        load_tests(); // after the memory fill
        loaded = 1'b1;
        wait (finished);
        @(negedge clk);
        if (exp_addr_q.size() != 0) begin
            other_errors++;
            $display("%0d expected stores never happened", exp_addr_q.size());
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // 50 cycles per word, 4x for memory latency
    initial begin
        wait (loaded);
        repeat (n_words * 50 * 4 + 20) @(posedge clk);
        other_errors++;
        $display("timeout, the end marker store never came");
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== tests/mem_model.sv ====
module mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_pkg::rv32i_word imem_address,
    input  logic                 imem_read,
    output rv32i_pkg::rv32i_word imem_rdata,
    output logic                 imem_resp,
    input  rv32i_pkg::rv32i_word dmem_address,
    input  logic                 dmem_read,
    input  logic                 dmem_write,
    input  rv32i_pkg::rv32i_word dmem_wdata,
    output rv32i_pkg::rv32i_word dmem_rdata,
    output logic                 dmem_resp
);
    import rv32i_pkg::*;

    rv32i_word   mem [0:16383]; // 64 KiB, word indexed
    logic [31:0] lfsr;
    logic        ibusy, dbusy;  // latency drawn for the open request
    int          icnt, dcnt;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_latency(output int lat);
        lat = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr); // one step per bit
            lat  = (lat << 1) | lfsr[0];
        end
    endtask

    initial begin
        lfsr       = 32'h1448e17d;
        ibusy      = 1'b0;
        dbusy      = 1'b0;
        icnt       = 0;
        dcnt       = 0;
        imem_resp  = 1'b0;
        dmem_resp  = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;
        for (int i = 0; i < 16384; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (i << 2); // fill tied to the byte address
        end
    end

    // responses change on the falling edge only
    always @(negedge clk) begin
        imem_resp = 1'b0;
        dmem_resp = 1'b0;
        if (rst) begin
            ibusy = 1'b0;
            dbusy = 1'b0;
        end else begin
            if (imem_read) begin
                if (!ibusy) begin
                    draw_latency(icnt);
                    ibusy = 1'b1;
                end
                if (icnt == 0) begin
                    imem_resp  = 1'b1;
                    imem_rdata = mem[imem_address[15:2]];
                    ibusy      = 1'b0;
                end else begin
                    icnt--;
                end
            end
            if (dmem_read || dmem_write) begin
                if (!dbusy) begin
                    draw_latency(dcnt);
                    dbusy = 1'b1;
                end
                if (dcnt == 0) begin
                    dmem_resp = 1'b1;
                    dbusy     = 1'b0;
                    if (dmem_write) begin
                        mem[dmem_address[15:2]] = dmem_wdata;
                    end else begin
                        dmem_rdata = mem[dmem_address[15:2]];
                    end
                end else begin
                    dcnt--;
                end
            end
        end
    end

endmodule

// ==== tests/clk_gen.sv ====
module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // period 20
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0; // released on a falling edge
    end

endmodule

// ==== hdl/rv32i_core.sv ====
module rv32i_core (
    input  logic                 clk,
    input  logic                 rst,
    output rv32i_pkg::rv32i_word imem_address,
    output logic                 imem_read,
    input  rv32i_pkg::rv32i_word imem_rdata,
    input  logic                 imem_resp,
    output rv32i_pkg::rv32i_word dmem_address,
    output logic                 dmem_read,
    output logic                 dmem_write,
    output logic [3:0]           dmem_wmask,
    input  rv32i_pkg::rv32i_word dmem_rdata,
    output rv32i_pkg::rv32i_word dmem_wdata,
    input  logic                 dmem_resp
);
    import rv32i_pkg::*;

    // stage outputs (_d) and register outputs (_q)
    if_id_t    if_d, if_q;
    id_ex_t    id_d, id_q;
    ex_mem_t   ex_d, ex_q;
    mem_wb_t   mem_d, mem_q;

    logic      pc_stall, if_id_stall, if_id_flush, id_ex_stall, id_ex_flush;
    logic      ex_mem_stall, mem_wb_stall;
    logic      fetch_wait, mem_wait;
    logic      redirect;
    rv32i_word redirect_pc;
    rv32i_word mem_fwd_data;
    reg_idx_t  rs1, rs2;
    fwd_sel_t  fwd_a, fwd_b;

    fetch_stage u_fetch (
        .clk(clk), .rst(rst),
        .pc_stall(pc_stall),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_rdata(imem_rdata), .imem_resp(imem_resp),
        .imem_address(imem_address), .imem_read(imem_read),
        .fetch_wait(fetch_wait),
        .if_out(if_d)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .rst(rst), .stall(if_id_stall), .flush(if_id_flush), .d(if_d), .q(if_q)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst),
        .id_in(if_q),
        .wb_rd(mem_q.rd), .wb_data(mem_q.wb_data), .wb_we(mem_q.reg_write), // writeback port
        .id_out(id_d),
        .rs1(rs1), .rs2(rs2)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst(rst), .stall(id_ex_stall), .flush(id_ex_flush), .d(id_d), .q(id_q)
    );

    execute_stage u_execute (
        .ex_in(id_q),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_fwd_data(mem_fwd_data), .wb_fwd_data(mem_q.wb_data),
        .ex_out(ex_d),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    // nothing ever flushes past execute
    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .rst(rst), .stall(ex_mem_stall), .flush(1'b0), .d(ex_d), .q(ex_q)
    );

    mem_stage u_mem (
        .clk(clk), .rst(rst),
        .mem_in(ex_q),
        .dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp),
        .dmem_address(dmem_address), .dmem_read(dmem_read), .dmem_write(dmem_write),
        .dmem_wmask(dmem_wmask), .dmem_wdata(dmem_wdata),
        .mem_wait(mem_wait),
        .mem_out(mem_d),
        .mem_fwd_data(mem_fwd_data)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .rst(rst), .stall(mem_wb_stall), .flush(1'b0), .d(mem_d), .q(mem_q)
    );

    hazard_ctrl u_hazard (
        .rs1(rs1), .rs2(rs2),
        .ex_rs1(id_q.rs1), .ex_rs2(id_q.rs2), .ex_rd(id_q.rd), .ex_mem_read(id_q.mem_read),
        .mem_rd(ex_q.rd), .mem_reg_write(ex_q.reg_write),
        .wb_rd(mem_q.rd), .wb_reg_write(mem_q.reg_write),
        .redirect(redirect), .fetch_wait(fetch_wait), .mem_wait(mem_wait),
        .pc_stall(pc_stall),
        .if_id_stall(if_id_stall), .if_id_flush(if_id_flush),
        .id_ex_stall(id_ex_stall), .id_ex_flush(id_ex_flush),
        .ex_mem_stall(ex_mem_stall), .mem_wb_stall(mem_wb_stall),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

endmodule

// ==== hdl/hazard_ctrl.sv ====
module hazard_ctrl (
    input  rv32i_pkg::reg_idx_t rs1,          // from decode
    input  rv32i_pkg::reg_idx_t rs2,
    input  rv32i_pkg::reg_idx_t ex_rs1,       // instruction in execute
    input  rv32i_pkg::reg_idx_t ex_rs2,
    input  rv32i_pkg::reg_idx_t ex_rd,
    input  logic                ex_mem_read,
    input  rv32i_pkg::reg_idx_t mem_rd,
    input  logic                mem_reg_write,
    input  rv32i_pkg::reg_idx_t wb_rd,
    input  logic                wb_reg_write,
    input  logic                redirect,
    input  logic                fetch_wait,
    input  logic                mem_wait,
    output logic                pc_stall,
    output logic                if_id_stall,
    output logic                if_id_flush,
    output logic                id_ex_stall,
    output logic                id_ex_flush,
    output logic                ex_mem_stall,
    output logic                mem_wb_stall,
    output rv32i_pkg::fwd_sel_t fwd_a,
    output rv32i_pkg::fwd_sel_t fwd_b
);
    import rv32i_pkg::*;

    logic load_use;

    function automatic fwd_sel_t pick_fwd(input reg_idx_t src);
        if (src == '0) begin
            return fwd_none; // x0 never forwarded
        end
        if (mem_reg_write && mem_rd == src) begin
            return fwd_mem;
        end
        if (wb_reg_write && wb_rd == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    // load in execute feeding decode
    assign load_use = ex_mem_read & (ex_rd != '0) & ((ex_rd == rs1) | (ex_rd == rs2));

    assign pc_stall     = mem_wait | fetch_wait | load_use;
    assign if_id_stall  = mem_wait | (~redirect & (fetch_wait | load_use)); // redirect flushes
    assign if_id_flush  = redirect;
    assign id_ex_stall  = mem_wait;
    assign id_ex_flush  = redirect | load_use | fetch_wait; // bubble into execute
    assign ex_mem_stall = mem_wait;
    assign mem_wb_stall = mem_wait;

    always_comb begin
        fwd_a = pick_fwd(ex_rs1);
        fwd_b = pick_fwd(ex_rs2);
    end

endmodule

// ==== hdl/mem_stage.sv ====
module mem_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_pkg::ex_mem_t   mem_in,
    input  rv32i_pkg::rv32i_word dmem_rdata,
    input  logic                 dmem_resp,
    output rv32i_pkg::rv32i_word dmem_address,
    output logic                 dmem_read,
    output logic                 dmem_write,
    output logic [3:0]           dmem_wmask,
    output rv32i_pkg::rv32i_word dmem_wdata,
    output logic                 mem_wait,
    output rv32i_pkg::mem_wb_t   mem_out,
    output rv32i_pkg::rv32i_word mem_fwd_data
);
    import rv32i_pkg::*;

    logic      need_access;
    logic      done;   // access finished, instruction leaves this cycle
    rv32i_word load_q; // captured load word
    rv32i_word wb_val;

    assign need_access  = mem_in.valid & (mem_in.mem_read | mem_in.mem_write);
    assign mem_wait     = need_access & ~done; // held through the resp cycle
    assign dmem_read    = mem_wait & mem_in.mem_read;
    assign dmem_write   = mem_wait & mem_in.mem_write;
    assign dmem_address = mem_in.alu_result;
    assign dmem_wdata   = mem_in.store_data;
    assign dmem_wmask   = {4{dmem_write}}; // word stores only

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= (dmem_read | dmem_write) & dmem_resp; // one cycle, no re-request
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_read && dmem_resp) begin
            load_q <= dmem_rdata;
        end
    end

    always_comb begin
        case (mem_in.wb_sel)
            wb_load: wb_val = load_q;
            wb_pc4:  wb_val = mem_in.pc_plus4;
            default: wb_val = mem_in.alu_result;
        endcase
    end

    assign mem_fwd_data      = wb_val; // also the ex_mem forwarding source
    assign mem_out.rd        = mem_in.rd;
    assign mem_out.wb_data   = wb_val;
    assign mem_out.reg_write = mem_in.reg_write;
    assign mem_out.valid     = mem_in.valid;

endmodule

// ==== hdl/execute_stage.sv ====
module execute_stage (
    input  rv32i_pkg::id_ex_t    ex_in,
    input  rv32i_pkg::fwd_sel_t  fwd_a,
    input  rv32i_pkg::fwd_sel_t  fwd_b,
    input  rv32i_pkg::rv32i_word mem_fwd_data,
    input  rv32i_pkg::rv32i_word wb_fwd_data,
    output rv32i_pkg::ex_mem_t   ex_out,
    output logic                 redirect,
    output rv32i_pkg::rv32i_word redirect_pc
);
    import rv32i_pkg::*;

    rv32i_word rs1_val, rs2_val; // after forwarding
    rv32i_word op_a, op_b;
    rv32i_word alu_out;
    logic      taken;

    function automatic rv32i_word fwd_mux(input fwd_sel_t sel, input rv32i_word reg_val,
                                          input rv32i_word mem_val, input rv32i_word wb_val);
        case (sel)
            fwd_mem: return mem_val; // younger result wins
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign rs1_val = fwd_mux(fwd_a, ex_in.rs1_data, mem_fwd_data, wb_fwd_data);
    assign rs2_val = fwd_mux(fwd_b, ex_in.rs2_data, mem_fwd_data, wb_fwd_data);
    assign op_a    = (ex_in.op_a_sel == sel_a_pc) ? ex_in.pc : rs1_val;
    assign op_b    = (ex_in.op_b_sel == sel_b_imm) ? ex_in.imm : rs2_val;

    always_comb begin
        case (ex_in.alu_op)
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << op_b[4:0];
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> op_b[4:0];
            alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
            alu_or:   alu_out = op_a | op_b;
            alu_and:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b; // add, lui, auipc, addresses
        endcase
    end

    // branch compare always on register values
    always_comb begin
        case (ex_in.br_op)
            br_beq:  taken = rs1_val == rs2_val;
            br_bne:  taken = rs1_val != rs2_val;
            br_blt:  taken = $signed(rs1_val) < $signed(rs2_val);
            br_bge:  taken = $signed(rs1_val) >= $signed(rs2_val);
            br_bltu: taken = rs1_val < rs2_val;
            br_bgeu: taken = rs1_val >= rs2_val;
            br_jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = ex_in.valid & taken;
    // jalr: rs1+imm from alu, low bit dropped
    assign redirect_pc = (ex_in.br_op == br_jump && ex_in.op_a_sel == sel_a_reg) ?
                         {alu_out[xlen-1:1], 1'b0} : ex_in.pc + ex_in.imm;

    always_comb begin
        ex_out            = '0;
        ex_out.alu_result = alu_out;
        ex_out.store_data = rs2_val; // forwarded store data
        ex_out.rd         = ex_in.rd;
        ex_out.pc_plus4   = ex_in.pc + 32'd4; // link value
        ex_out.mem_read   = ex_in.mem_read;
        ex_out.mem_write  = ex_in.mem_write;
        ex_out.reg_write  = ex_in.reg_write;
        ex_out.wb_sel     = ex_in.wb_sel;
        ex_out.valid      = ex_in.valid;
    end

endmodule

// ==== hdl/decode_stage.sv ====
module decode_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_pkg::if_id_t    id_in,
    input  rv32i_pkg::reg_idx_t  wb_rd,
    input  rv32i_pkg::rv32i_word wb_data,
    input  logic                 wb_we,
    output rv32i_pkg::id_ex_t    id_out,
    output rv32i_pkg::reg_idx_t  rs1,
    output rv32i_pkg::reg_idx_t  rs2
);
    import rv32i_pkg::*;

    rv32i_word  regs [1:31]; // x0 is not stored
    rv32i_word  instr;
    rv32i_word  imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0] funct3;
    logic       use_rs1, use_rs2;

    assign instr  = id_in.instr;
    assign funct3 = instr[14:12];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    function automatic rv32i_word rf_read(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_we && wb_rd == idx) begin
            return wb_data; // write-through for same-cycle writeback
        end
        return regs[idx];
    endfunction

    always_comb begin
        id_out       = '0;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        id_out.pc    = id_in.pc;
        id_out.valid = id_in.valid;
        if (id_in.valid) begin
            case (opcode_t'(instr[6:0]))
                opc_lui: begin // x0 + imm
                    id_out.imm       = imm_u;
                    id_out.op_b_sel  = sel_b_imm;
                    id_out.reg_write = 1'b1;
                end
                opc_auipc: begin
                    id_out.imm       = imm_u;
                    id_out.op_a_sel  = sel_a_pc;
                    id_out.op_b_sel  = sel_b_imm;
                    id_out.reg_write = 1'b1;
                end
                opc_jal: begin // alu gives pc+imm
                    id_out.imm       = imm_j;
                    id_out.op_a_sel  = sel_a_pc;
                    id_out.op_b_sel  = sel_b_imm;
                    id_out.br_op     = br_jump;
                    id_out.wb_sel    = wb_pc4;
                    id_out.reg_write = 1'b1;
                end
                opc_jalr: begin // alu gives rs1+imm
                    use_rs1          = 1'b1;
                    id_out.imm       = imm_i;
                    id_out.op_b_sel  = sel_b_imm;
                    id_out.br_op     = br_jump;
                    id_out.wb_sel    = wb_pc4;
                    id_out.reg_write = 1'b1;
                end
                opc_branch: begin
                    use_rs1      = 1'b1;
                    use_rs2      = 1'b1;
                    id_out.imm   = imm_b;
                    id_out.br_op = br_op_t'({1'b1, funct3});
                end
                opc_load: begin // LW only
                    use_rs1          = 1'b1;
                    id_out.imm       = imm_i;
                    id_out.op_b_sel  = sel_b_imm;
                    id_out.mem_read  = 1'b1;
                    id_out.wb_sel    = wb_load;
                    id_out.reg_write = 1'b1;
                end
                opc_store: begin
                    use_rs1          = 1'b1;
                    use_rs2          = 1'b1; // store data
                    id_out.imm       = imm_s;
                    id_out.op_b_sel  = sel_b_imm;
                    id_out.mem_write = 1'b1;
                end
                opc_imm: begin
                    use_rs1          = 1'b1;
                    id_out.imm       = imm_i;
                    id_out.op_b_sel  = sel_b_imm;
                    id_out.alu_op    = alu_op_t'({instr[30] & (funct3 == 3'b101), funct3});
                    id_out.reg_write = 1'b1;
                end
                opc_op: begin
                    use_rs1          = 1'b1;
                    use_rs2          = 1'b1;
                    id_out.alu_op    = alu_op_t'({instr[30], funct3});
                    id_out.reg_write = 1'b1;
                end
                default: ; // unsupported opcodes pass as nops
            endcase
        end
        // unused sources read as x0, so no false hazards
        id_out.rs1      = use_rs1 ? instr[19:15] : '0;
        id_out.rs2      = use_rs2 ? instr[24:20] : '0;
        id_out.rd       = id_out.reg_write ? instr[11:7] : '0;
        id_out.rs1_data = rf_read(id_out.rs1);
        id_out.rs2_data = rf_read(id_out.rs2);
        rs1             = id_out.rs1;
        rs2             = id_out.rs2;
    end

    always_ff @(posedge clk) begin
        if (!rst && wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

// ==== hdl/fetch_stage.sv ====
module fetch_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pc_stall,
    input  logic                 redirect,
    input  rv32i_pkg::rv32i_word redirect_pc,
    input  rv32i_pkg::rv32i_word imem_rdata,
    input  logic                 imem_resp,
    output rv32i_pkg::rv32i_word imem_address,
    output logic                 imem_read,
    output logic                 fetch_wait,
    output rv32i_pkg::if_id_t    if_out
);
    import rv32i_pkg::*;

    rv32i_word pc;
    logic      redir_pend;   // redirect arrived mid-fetch
    rv32i_word redir_target; // where to go once the stale word lands

    assign imem_address = pc; // stable for the whole request
    assign fetch_wait   = imem_read & ~imem_resp;

    assign if_out.pc    = pc;
    assign if_out.instr = imem_rdata;
    assign if_out.valid = imem_read & imem_resp & ~redir_pend; // drop stale word

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= reset_pc;
            imem_read  <= 1'b0;
            redir_pend <= 1'b0;
        end else begin
            imem_read <= 1'b1; // always fetching once out of reset
            if (imem_resp && redir_pend) begin
                pc         <= redir_target; // stale word is back, go to the target
                redir_pend <= 1'b0;
            end else if (imem_read && !pc_stall) begin // first request keeps reset_pc
                pc <= redirect ? redirect_pc : pc + 32'd4;
            end
            if (redirect && fetch_wait) begin
                redir_pend <= 1'b1;
            end
        end
    end

    // where a redirect during a fetch points
    always_ff @(posedge clk) begin
        if (redirect && fetch_wait) begin
            redir_target <= redirect_pc;
        end
    end

endmodule

// ==== hdl/pipe_reg.sv ====
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall, // hold current contents
    input  logic     flush, // insert bubble
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (!stall) begin
            q <= flush ? payload_t'('0) : d; // stall wins over flush
        end
    end

endmodule

// ==== hdl/rv32i_pkg.sv ====
package rv32i_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] rv32i_word;
    typedef logic [4:0]      reg_idx_t;

    localparam rv32i_word reset_pc = 32'h0000_0000; // first fetch address

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_imm    = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_t;

    // encoded as {instr[30], funct3} so decode is a plain concat
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    // branch codes are {1, funct3}
    typedef enum logic [3:0] {
        br_none  = 4'b0000,
        br_jump  = 4'b0001,
        br_beq   = 4'b1000,
        br_bne   = 4'b1001,
        br_blt   = 4'b1100,
        br_bge   = 4'b1101,
        br_bltu  = 4'b1110,
        br_bgeu  = 4'b1111
    } br_op_t;

    typedef enum logic {sel_a_reg, sel_a_pc} op_a_sel_t;
    typedef enum logic {sel_b_reg, sel_b_imm} op_b_sel_t;
    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4} wb_sel_t;
    typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_t;

    // all-zero value of each payload is a bubble
    typedef struct packed {
        rv32i_word pc;
        rv32i_word instr;
        logic      valid;
    } if_id_t;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word rs1_data;
        rv32i_word rs2_data;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        rv32i_word imm;
        alu_op_t   alu_op;
        br_op_t    br_op;
        op_a_sel_t op_a_sel;
        op_b_sel_t op_b_sel;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        wb_sel_t   wb_sel;
        logic      valid;
    } id_ex_t;

    typedef struct packed {
        rv32i_word alu_result;
        rv32i_word store_data;
        reg_idx_t  rd;
        rv32i_word pc_plus4;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        wb_sel_t   wb_sel;
        logic      valid;
    } ex_mem_t;

    typedef struct packed {
        reg_idx_t  rd;
        rv32i_word wb_data;
        logic      reg_write;
        logic      valid;
    } mem_wb_t;

endpackage
